// File: src/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // Bus geometry
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int LED_W  = 8;

    // ------------------------------------------------------------------
    // Register map, byte offsets of 32-bit words
    // ------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] LED_OFS      = 8'h00; // R/W
    localparam logic [ADDR_W-1:0] DIP_OFS      = 8'h04; // RO
    localparam logic [ADDR_W-1:0] RNG_DATA_OFS = 8'h08; // Read pops
    localparam logic [ADDR_W-1:0] RNG_STAT_OFS = 8'h0C; // Write clears underflow
    localparam logic [ADDR_W-1:0] CTRL_OFS     = 8'h10;

    // CTRL bit positions
    localparam int CTRL_SAMPLE_BIT = 0;
    localparam int CTRL_IRQ_BIT    = 1;

    localparam logic [DATA_W-1:0] UNMAPPED_RDATA = 32'hDEAD_BEEF;
    localparam logic [DATA_W-1:0] LFSR_POLY      = 32'hA300_0000; // Galois taps

    // AXI response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_e;

    // Single-cycle access issued to the register block
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } bus_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WRESP = 2'd1,
        ST_RDATA = 2'd2
    } fsm_state_e;

endpackage

`default_nettype wire

// File: src/sample_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_timer #(
    parameter int SAMPLE_PERIOD = 16
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic enable_i,
    output logic tick_o
);

    localparam int CNT_W = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SAMPLE_PERIOD - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || !enable_i) begin
            cnt_q <= '0; // Restart on every disable
        end else if (cnt_q == LAST) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign tick_o = enable_i && (cnt_q == LAST);

    // A tick needs sampling switched on in the cycle before
    a_tick_needs_enable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        tick_o && (SAMPLE_PERIOD > 1) |-> $past(enable_i)
    );

endmodule

`default_nettype wire

// File: src/rng_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rng_fifo #(
    parameter int                            FIFO_DEPTH = 8,
    parameter logic [periph_pkg::DATA_W-1:0] LFSR_SEED  = 32'h1ACE_B00C
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            tick_i,
    input  logic                            pop_i,
    input  logic                            clear_underflow_i,
    output logic [periph_pkg::DATA_W-1:0]   head_o,
    output logic [$clog2(FIFO_DEPTH):0]     count_o,
    output logic                            full_o,
    output logic                            empty_o,
    output logic                            underflow_o
);

    import periph_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0]         lfsr_q;
    logic [DATA_W-1:0]         lfsr_next;
    logic [DATA_W-1:0]         mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [PTR_W:0]            count_q;
    logic                      underflow_q;
    logic                      push;
    logic                      pop_ok;

    // ------------------------------------------------------------------
    // Entropy source
    // ------------------------------------------------------------------
    // Right shift, fold taps back in when a one drops out
    assign lfsr_next = {1'b0, lfsr_q[DATA_W-1:1]} ^ (lfsr_q[0] ? LFSR_POLY : '0);

    assign push   = tick_i && !full_o;
    assign pop_ok = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (push) begin
            lfsr_q <= lfsr_next; // Step only once the state is stored
        end
    end

    // ------------------------------------------------------------------
    // Sample storage
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= lfsr_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            underflow_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // Depth is a power of two
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // Idle or push and pop together
            endcase
            // Sticky until software clears it
            if (pop_i && empty_o) begin
                underflow_q <= 1'b1;
            end else if (clear_underflow_i) begin
                underflow_q <= 1'b0;
            end
        end
    end

    assign head_o      = mem_q[rd_ptr_q];
    assign count_o     = count_q;
    assign full_o      = (count_q == FIFO_DEPTH[PTR_W:0]);
    assign empty_o     = (count_q == '0);
    assign underflow_o = underflow_q;

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
        count_q <= FIFO_DEPTH
    );

endmodule

`default_nettype wire

// File: src/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  periph_pkg::bus_op_e           bus_op_i,
    input  logic [periph_pkg::ADDR_W-1:0] bus_addr_i,
    input  logic [periph_pkg::DATA_W-1:0] bus_wdata_i,
    output logic [periph_pkg::DATA_W-1:0] bus_rdata_o,
    output periph_pkg::resp_e             bus_resp_o,
    input  logic [periph_pkg::LED_W-1:0]  dip_switches_i,
    output logic [periph_pkg::LED_W-1:0]  leds_o,
    output logic                          irq_o,
    output logic                          sample_en_o,
    output logic                          pop_o,
    output logic                          clear_underflow_o,
    input  logic [periph_pkg::DATA_W-1:0] head_i,
    input  logic [$clog2(FIFO_DEPTH):0]   count_i,
    input  logic                          full_i,
    input  logic                          empty_i,
    input  logic                          underflow_i
);

    import periph_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic [LED_W-1:0]  led_q;
    logic              sample_en_q;
    logic              irq_en_q;
    logic              irq_q;
    logic [DATA_W-1:0] rd_word;
    logic              mapped;   // Offset exists
    logic              writable; // Offset accepts writes
    logic              rd_en;
    logic              wr_en;

    assign rd_en = (bus_op_i == OP_READ);
    assign wr_en = (bus_op_i == OP_WRITE);

    // ------------------------------------------------------------------
    // Decode and read mux
    // ------------------------------------------------------------------
    always_comb begin
        rd_word  = UNMAPPED_RDATA;
        mapped   = 1'b1;
        writable = 1'b0;
        case (bus_addr_i)
            LED_OFS: begin
                rd_word  = {{(DATA_W-LED_W){1'b0}}, led_q};
                writable = 1'b1;
            end
            DIP_OFS:      rd_word = {{(DATA_W-LED_W){1'b0}}, dip_switches_i};
            RNG_DATA_OFS: rd_word = empty_i ? '0 : head_i;
            RNG_STAT_OFS: begin
                // Flags on top, fill count at the bottom
                rd_word  = {full_i, empty_i, underflow_i, {(DATA_W-3-CNT_W){1'b0}}, count_i};
                writable = 1'b1;
            end
            CTRL_OFS: begin
                rd_word                  = '0;
                rd_word[CTRL_SAMPLE_BIT] = sample_en_q;
                rd_word[CTRL_IRQ_BIT]    = irq_en_q;
                writable                 = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    assign bus_rdata_o = rd_word;
    assign bus_resp_o  = ((rd_en && !mapped) || (wr_en && !writable)) ? RESP_SLVERR : RESP_OKAY;

    // Side effects on the FIFO
    assign pop_o             = rd_en && (bus_addr_i == RNG_DATA_OFS);
    assign clear_underflow_o = wr_en && (bus_addr_i == RNG_STAT_OFS);

    // ------------------------------------------------------------------
    // Writable registers and interrupt
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_q       <= '0;
            sample_en_q <= 1'b0;
            irq_en_q    <= 1'b0;
            irq_q       <= 1'b0;
        end else begin
            if (wr_en && bus_addr_i == LED_OFS) begin
                led_q <= bus_wdata_i[LED_W-1:0];
            end
            if (wr_en && bus_addr_i == CTRL_OFS) begin
                sample_en_q <= bus_wdata_i[CTRL_SAMPLE_BIT];
                irq_en_q    <= bus_wdata_i[CTRL_IRQ_BIT];
            end
            irq_q <= irq_en_q && !empty_i; // Level, data waiting
        end
    end

    assign leds_o      = led_q;
    assign sample_en_o = sample_en_q;
    assign irq_o       = irq_q;

endmodule

`default_nettype wire

// File: src/axil_slave_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave_fsm (
    input  logic                              clk_i,
    input  logic                              rst_i,
    // Write address and data
    input  logic                              aw_valid_i,
    output logic                              aw_ready_o,
    input  logic [periph_pkg::ADDR_W-1:0]     aw_addr_i,
    input  logic                              w_valid_i,
    output logic                              w_ready_o,
    input  logic [periph_pkg::DATA_W-1:0]     w_data_i,
    input  logic [periph_pkg::DATA_W/8-1:0]   w_strb_i,
    // Write response
    output logic                              b_valid_o,
    input  logic                              b_ready_i,
    output periph_pkg::resp_e                 b_resp_o,
    // Read address and data
    input  logic                              ar_valid_i,
    output logic                              ar_ready_o,
    input  logic [periph_pkg::ADDR_W-1:0]     ar_addr_i,
    output logic                              r_valid_o,
    input  logic                              r_ready_i,
    output logic [periph_pkg::DATA_W-1:0]     r_data_o,
    output periph_pkg::resp_e                 r_resp_o,
    // Register block side
    output periph_pkg::bus_op_e               bus_op_o,
    output logic [periph_pkg::ADDR_W-1:0]     bus_addr_o,
    output logic [periph_pkg::DATA_W-1:0]     bus_wdata_o,
    input  logic [periph_pkg::DATA_W-1:0]     bus_rdata_i,
    input  periph_pkg::resp_e                 bus_resp_i
);

    import periph_pkg::*;

    fsm_state_e        state_q;
    logic              wr_accept;
    logic              rd_accept;
    logic [DATA_W-1:0] r_data_q;
    resp_e             r_resp_q;
    resp_e             b_resp_q;

    // ------------------------------------------------------------------
    // Acceptance, writes win over reads
    // ------------------------------------------------------------------
    assign wr_accept = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
    assign rd_accept = (state_q == ST_IDLE) && !(aw_valid_i && w_valid_i) && ar_valid_i;

    assign aw_ready_o = wr_accept;
    assign w_ready_o  = wr_accept;
    assign ar_ready_o = rd_accept;

    always_comb begin
        bus_op_o = OP_NONE;
        if (wr_accept) begin
            bus_op_o = OP_WRITE;
        end else if (rd_accept) begin
            bus_op_o = OP_READ;
        end
    end

    assign bus_addr_o  = wr_accept ? aw_addr_i : ar_addr_i;
    assign bus_wdata_o = w_data_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_accept) begin
                        state_q <= ST_WRESP;
                    end else if (rd_accept) begin
                        state_q <= ST_RDATA;
                    end
                end
                ST_WRESP: if (b_ready_i) state_q <= ST_IDLE;
                ST_RDATA: if (r_ready_i) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // Capture the register block answer on the acceptance cycle
    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            b_resp_q <= bus_resp_i;
        end
        if (rd_accept) begin
            r_data_q <= bus_rdata_i;
            r_resp_q <= bus_resp_i;
        end
    end

    assign b_valid_o = (state_q == ST_WRESP);
    assign b_resp_o  = b_resp_q;
    assign r_valid_o = (state_q == ST_RDATA);
    assign r_data_o  = r_data_q;
    assign r_resp_o  = r_resp_q;

    // ------------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------------
    a_b_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o)
    );

    a_r_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o)
    );

    // Each op lasts one cycle and is followed by exactly one response
    a_one_in_flight: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (bus_op_o != OP_NONE) |=> (bus_op_o == OP_NONE) && (b_valid_o ^ r_valid_o)
    );

    // Only full-word writes are supported
    a_full_word: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wr_accept |-> &w_strb_i
    );

endmodule

`default_nettype wire

// File: src/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter int                            FIFO_DEPTH    = 8,
    parameter int                            SAMPLE_PERIOD = 16,
    parameter logic [periph_pkg::DATA_W-1:0] LFSR_SEED     = 32'h1ACE_B00C
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            aw_valid_i,
    output logic                            aw_ready_o,
    input  logic [periph_pkg::ADDR_W-1:0]   aw_addr_i,
    input  logic                            w_valid_i,
    output logic                            w_ready_o,
    input  logic [periph_pkg::DATA_W-1:0]   w_data_i,
    input  logic [periph_pkg::DATA_W/8-1:0] w_strb_i,
    output logic                            b_valid_o,
    input  logic                            b_ready_i,
    output periph_pkg::resp_e               b_resp_o,
    input  logic                            ar_valid_i,
    output logic                            ar_ready_o,
    input  logic [periph_pkg::ADDR_W-1:0]   ar_addr_i,
    output logic                            r_valid_o,
    input  logic                            r_ready_i,
    output logic [periph_pkg::DATA_W-1:0]   r_data_o,
    output periph_pkg::resp_e               r_resp_o,
    input  logic [periph_pkg::LED_W-1:0]    dip_switches_i,
    output logic [periph_pkg::LED_W-1:0]    leds_o,
    output logic                            irq_o
);

    import periph_pkg::*;

    bus_op_e                   bus_op;
    logic [ADDR_W-1:0]         bus_addr;
    logic [DATA_W-1:0]         bus_wdata;
    logic [DATA_W-1:0]         bus_rdata;
    resp_e                     bus_resp;
    logic                      sample_en;
    logic                      tick;
    logic                      pop;
    logic                      clear_underflow;
    logic [DATA_W-1:0]         head;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic                      full;
    logic                      empty;
    logic                      underflow;

    // ------------------------------------------------------------------
    // Bus front end and register block
    // ------------------------------------------------------------------
    axil_slave_fsm u_axil_slave_fsm (
        .clk_i, .rst_i,
        .aw_valid_i, .aw_ready_o, .aw_addr_i,
        .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
        .b_valid_o, .b_ready_i, .b_resp_o,
        .ar_valid_i, .ar_ready_o, .ar_addr_i,
        .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o,
        .bus_op_o    (bus_op),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_rdata_i (bus_rdata),
        .bus_resp_i  (bus_resp)
    );

    periph_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_periph_regs (
        .clk_i, .rst_i,
        .bus_op_i          (bus_op),
        .bus_addr_i        (bus_addr),
        .bus_wdata_i       (bus_wdata),
        .bus_rdata_o       (bus_rdata),
        .bus_resp_o        (bus_resp),
        .dip_switches_i, .leds_o, .irq_o,
        .sample_en_o       (sample_en),
        .pop_o             (pop),
        .clear_underflow_o (clear_underflow),
        .head_i            (head),
        .count_i           (count),
        .full_i            (full),
        .empty_i           (empty),
        .underflow_i       (underflow)
    );

    // Random number path
    sample_timer #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) u_sample_timer (
        .clk_i, .rst_i,
        .enable_i (sample_en),
        .tick_o   (tick)
    );

    rng_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .LFSR_SEED  (LFSR_SEED)
    ) u_rng_fifo (
        .clk_i, .rst_i,
        .tick_i            (tick),
        .pop_i             (pop),
        .clear_underflow_i (clear_underflow),
        .head_o            (head),
        .count_o           (count),
        .full_o            (full),
        .empty_o           (empty),
        .underflow_o       (underflow)
    );

endmodule

`default_nettype wire

// File: verif/tb_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

    import periph_pkg::*;

    localparam int NUM_OPS         = 400;             // Access budget incl. status polls
    localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + 2000;
    localparam int NUM_POPS        = 40;
    localparam int DEPTH           = 8;
    localparam logic [31:0] SEED   = 32'h1ACE_B00C;

    logic              clk_i = 1'b0;
    logic              rst_i;
    logic              aw_valid_i;
    logic              aw_ready_o;
    logic [ADDR_W-1:0] aw_addr_i;
    logic              w_valid_i;
    logic              w_ready_o;
    logic [DATA_W-1:0] w_data_i;
    logic [3:0]        w_strb_i;
    logic              b_valid_o;
    logic              b_ready_i;
    resp_e             b_resp_o;
    logic              ar_valid_i;
    logic              ar_ready_o;
    logic [ADDR_W-1:0] ar_addr_i;
    logic              r_valid_o;
    logic              r_ready_i;
    logic [DATA_W-1:0] r_data_o;
    resp_e             r_resp_o;
    logic [LED_W-1:0]  dip_switches_i;
    logic [LED_W-1:0]  leds_o;
    logic              irq_o;

    // Reference model state
    logic [7:0]  model_led;
    logic        model_sample_en;
    logic        model_irq_en;
    logic [31:0] model_lfsr;
    logic        model_underflow;
    int          errors = 0;
    int          checks = 0;

    periph_top u_periph_top (.*);

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Model and check helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_lfsr(input logic [31:0] v);
        next_lfsr = {1'b0, v[31:1]} ^ (v[0] ? 32'hA300_0000 : 32'h0); // Galois, right shift
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // AXI-Lite master, all tasks start and end 2 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output resp_e resp);
        int   stall;
        logic hs;
        aw_valid_i = 1'b1;
        aw_addr_i  = addr;
        w_valid_i  = 1'b1;
        w_data_i   = data;
        do begin
            @(negedge clk_i);
            hs = aw_ready_o && w_ready_o;
            @(posedge clk_i);
            #2;
        end while (!hs);
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b0;
        stall = int'($urandom_range(3, 0)); // Back-pressure on B
        repeat (stall) begin
            @(posedge clk_i);
            #2;
        end
        b_ready_i = 1'b1;
        do begin
            @(negedge clk_i);
            hs   = b_valid_o;
            resp = b_resp_o;
            @(posedge clk_i);
            #2;
        end while (!hs);
        b_ready_i = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output resp_e resp, output logic irq_snap);
        int   stall;
        logic hs;
        ar_valid_i = 1'b1;
        ar_addr_i  = addr;
        do begin
            @(negedge clk_i);
            hs = ar_ready_o;
            @(posedge clk_i);
            #2;
        end while (!hs);
        ar_valid_i = 1'b0;
        irq_snap   = irq_o; // Reflects FIFO state of the acceptance cycle
        stall = int'($urandom_range(3, 0));
        repeat (stall) begin
            @(posedge clk_i);
            #2;
        end
        r_ready_i = 1'b1;
        do begin
            @(negedge clk_i);
            hs   = r_valid_o;
            data = r_data_o;
            resp = r_resp_o;
            @(posedge clk_i);
            #2;
        end while (!hs);
        r_ready_i = 1'b0;
    endtask

    // Status read with flag, count and interrupt checks
    task automatic read_status(output logic [31:0] status);
        resp_e       resp;
        logic        irq_snap;
        logic [3:0]  cnt;
        axil_read(RNG_STAT_OFS, status, resp, irq_snap);
        cnt = status[3:0];
        check_value("status_resp", 32'(RESP_OKAY), 32'(resp));
        check_value("status_underflow", 32'(model_underflow), 32'(status[29]));
        check_value("status_full", 32'(cnt == 4'(DEPTH)), 32'(status[31]));
        check_value("status_empty", 32'(cnt == 4'd0), 32'(status[30]));
        check_value("irq_level", 32'(model_irq_en && !status[30]), 32'(irq_snap));
        checks++;
        assert (cnt <= 4'(DEPTH)) else begin
            errors++;
            $display("ERROR status_count: fill count %0d is larger than the FIFO depth", cnt);
        end
    endtask

    task automatic write_ctrl(input logic sample_en, input logic irq_en);
        resp_e resp;
        axil_write(CTRL_OFS, {30'd0, irq_en, sample_en}, resp);
        check_value("ctrl_write_resp", 32'(RESP_OKAY), 32'(resp));
        model_sample_en = sample_en;
        model_irq_en    = irq_en;
    endtask

    // Poll until a sample waits, then pop and compare with the model LFSR
    task automatic pop_sample(input string name);
        logic [31:0] status;
        logic [31:0] rdata;
        resp_e       resp;
        logic        irq_snap;
        do begin
            read_status(status);
        end while (status[30]);
        axil_read(RNG_DATA_OFS, rdata, resp, irq_snap);
        check_value(name, model_lfsr, rdata);
        check_value("rng_data_resp", 32'(RESP_OKAY), 32'(resp));
        model_lfsr = next_lfsr(model_lfsr);
    endtask

    // Poll status until the FIFO has filled up
    task automatic wait_full();
        logic [31:0] status;
        do begin
            read_status(status);
        end while (!status[31]);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] rdata;
        logic [31:0] status;
        logic [7:0]  addr;
        resp_e       resp;
        logic        irq_snap;
        int          sel;
        void'($urandom(32'haa98));
        rst_i          = 1'b1;
        aw_valid_i     = 1'b0;
        aw_addr_i      = '0;
        w_valid_i      = 1'b0;
        w_data_i       = '0;
        w_strb_i       = 4'hF;
        b_ready_i      = 1'b0;
        ar_valid_i     = 1'b0;
        ar_addr_i      = '0;
        r_ready_i      = 1'b0;
        dip_switches_i = 8'($urandom());
        model_led       = '0;
        model_sample_en = 1'b0;
        model_irq_en    = 1'b0;
        model_lfsr      = SEED;
        model_underflow = 1'b0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        check_value("reset_leds", 32'h0, 32'(leds_o));
        check_value("reset_irq", 32'h0, 32'(irq_o));

        // LED writes, LED readback and DIP reads in random order
        repeat (24) begin
            sel = int'($urandom_range(2, 0));
            if (sel == 0) begin
                rdata = $urandom();
                axil_write(LED_OFS, rdata, resp);
                model_led = rdata[7:0];
                check_value("led_write_resp", 32'(RESP_OKAY), 32'(resp));
                check_value("led_output", 32'(model_led), 32'(leds_o));
            end else if (sel == 1) begin
                axil_read(LED_OFS, rdata, resp, irq_snap);
                check_value("led_readback", 32'(model_led), rdata);
                check_value("led_read_resp", 32'(RESP_OKAY), 32'(resp));
            end else begin
                dip_switches_i = 8'($urandom());
                axil_read(DIP_OFS, rdata, resp, irq_snap);
                check_value("dip_read", 32'(dip_switches_i), rdata);
                check_value("dip_read_resp", 32'(RESP_OKAY), 32'(resp));
            end
        end

        // Random samples, interrupt enabled for the first half only
        write_ctrl(1'b1, 1'b1);
        wait_full();
        for (int i = 0; i < NUM_POPS; i++) begin
            if (i == NUM_POPS / 2) begin
                write_ctrl(1'b1, 1'b0);
                wait_full();
            end
            pop_sample("rng_data");
        end

        // Drain, then underflow and its clear
        wait_full();
        write_ctrl(1'b0, 1'b1);
        read_status(status);
        while (!status[30]) begin
            pop_sample("rng_drain");
            read_status(status);
        end
        axil_read(RNG_DATA_OFS, rdata, resp, irq_snap);
        check_value("rng_empty_read", 32'h0, rdata);
        model_underflow = 1'b1;
        read_status(status);
        axil_write(RNG_STAT_OFS, 32'h0, resp);
        check_value("stat_write_resp", 32'(RESP_OKAY), 32'(resp));
        model_underflow = 1'b0;
        read_status(status);

        // Bad accesses
        repeat (6) begin
            addr = 8'($urandom_range(255, 20));
            axil_read(addr, rdata, resp, irq_snap);
            check_value("unmapped_read", UNMAPPED_RDATA, rdata);
            check_value("unmapped_read_resp", 32'(RESP_SLVERR), 32'(resp));
            sel  = int'($urandom_range(2, 0));
            addr = (sel == 0) ? DIP_OFS : (sel == 1) ? RNG_DATA_OFS : addr;
            axil_write(addr, $urandom(), resp);
            check_value("bad_write_resp", 32'(RESP_SLVERR), 32'(resp));
        end
        axil_read(LED_OFS, rdata, resp, irq_snap);
        check_value("led_after_bad", 32'(model_led), rdata);
        axil_read(CTRL_OFS, rdata, resp, irq_snap);
        check_value("ctrl_after_bad", {30'd0, model_irq_en, model_sample_en}, rdata);
        axil_read(DIP_OFS, rdata, resp, irq_snap);
        check_value("dip_after_bad", 32'(dip_switches_i), rdata);
        read_status(status);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/periph_pkg.sv
src/sample_timer.sv
src/rng_fifo.sv
src/periph_regs.sv
src/axil_slave_fsm.sv
src/periph_top.sv
verif/tb_periph_top.sv

// File: Makefile
# Verilator flow for the peripheral block

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)
